// File: compile.f
verilog/wrb_pkg.sv
verilog/wrb_slot_alloc.sv
verilog/wrb_id_lists.sv
verilog/wrb_release_arb.sv
verilog/wrb_bank_top.sv
verif/wrb_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the write-response bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module wrb_tb \
  -f compile.f -o wrb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/wrb_sim)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

// File: verif/wrb_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the write-response bank top level
// Stimulus table applied once per clock, queue-based reference model
// Per-cycle output checks, error count and watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wrb_tb;

  import wrb_pkg::*;

  // One row of the stimulus table
  typedef struct packed {
    logic       res_req;
    id_t        res_id;
    logic       in_valid;
    id_t        in_id;
    slot_mask_t en;
    logic       out_ready;
  } step_t;

  logic       clk_i;
  logic       rst_ni;
  id_t        res_id_i;
  logic       res_ready_i;
  logic       res_valid_o;
  slot_t      res_slot_o;
  logic       in_valid_i;
  msg_t       in_msg_i;
  logic       in_ready_o;
  slot_mask_t release_en_i;
  logic       out_ready_i;
  logic       out_valid_o;
  msg_t       out_msg_o;
  slot_mask_t released_o;

  step_t      steps[$];
  string      names[$];
  int         errors;

  // Reference model state
  slot_mask_t occ_m;
  slot_t      resv_m [NumIds][$];
  slot_t      filled_m [NumIds][$];
  msg_t       store_m [NumSlots];
  logic       out_valid_m;
  msg_t       out_msg_m;
  slot_t      out_slot_m;

  wrb_bank_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_id_i     (res_id_i),
    .res_ready_i  (res_ready_i),
    .res_valid_o  (res_valid_o),
    .res_slot_o   (res_slot_o),
    .in_valid_i   (in_valid_i),
    .in_msg_i     (in_msg_i),
    .in_ready_o   (in_ready_o),
    .release_en_i (release_en_i),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_msg_o    (out_msg_o),
    .released_o   (released_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic add_step(input string nm, input logic res_req, input int res_id,
                          input logic in_valid, input int in_id,
                          input slot_mask_t en, input logic out_ready);
    step_t s;
    s.res_req   = res_req;
    s.res_id    = id_t'(res_id);
    s.in_valid  = in_valid;
    s.in_id     = id_t'(in_id);
    s.en        = en;
    s.out_ready = out_ready;
    steps.push_back(s);
    names.push_back(nm);
  endtask

  task automatic build_table();
    // Reset state, no ID may accept a message yet
    add_step("idle_in0", 0, 0, 1, 0, 8'h00, 1);
    add_step("idle_in1", 0, 0, 1, 1, 8'h00, 1);
    add_step("idle_in2", 0, 0, 1, 2, 8'h00, 1);
    add_step("idle_in3", 0, 0, 1, 3, 8'h00, 1);
    // Fill all eight slots, then one more request
    add_step("res_s0", 1, 0, 0, 0, 8'h00, 1);
    add_step("res_s1", 1, 1, 0, 0, 8'h00, 1);
    add_step("res_s2", 1, 0, 0, 0, 8'h00, 1);
    add_step("res_s3", 1, 2, 0, 0, 8'h00, 1);
    add_step("res_s4", 1, 3, 0, 0, 8'h00, 1);
    add_step("res_s5", 1, 1, 0, 0, 8'h00, 1);
    add_step("res_s6", 1, 0, 0, 0, 8'h00, 1);
    add_step("res_s7", 1, 2, 0, 0, 8'h00, 1);
    add_step("res_full", 1, 1, 0, 0, 8'h00, 1);
    add_step("fill_id1a", 0, 0, 1, 1, 8'h00, 1);
    add_step("fill_id0a", 0, 0, 1, 0, 8'h00, 1);
    add_step("fill_id2a", 0, 0, 1, 2, 8'h00, 1);
    add_step("fill_id0b", 0, 0, 1, 0, 8'h00, 1);
    // Enables only on slots that are not tails
    add_step("en_no_tail", 0, 0, 0, 0, 8'hF0, 1);
    add_step("rel_single", 0, 0, 0, 0, 8'h02, 1);
    add_step("bp_hold1", 0, 0, 0, 0, 8'hFF, 0);
    add_step("bp_hold2", 0, 0, 0, 0, 8'hFF, 0);
    add_step("bp_drain", 0, 0, 0, 0, 8'hFF, 1);
    add_step("rel_next", 0, 0, 0, 0, 8'hFF, 1);
    // Reuse of a freed slot with a fill of the same ID in one cycle
    add_step("reuse_fill", 1, 3, 1, 3, 8'hFF, 1);
    add_step("fill_fwd", 0, 0, 1, 3, 8'hFF, 1);
    add_step("fill_id0c", 0, 0, 1, 0, 8'hFF, 1);
    add_step("fill_id1b", 0, 0, 1, 1, 8'hFF, 1);
    add_step("fill_id2b", 0, 0, 1, 2, 8'hFF, 1);
    add_step("tail_block", 0, 0, 0, 0, 8'h00, 1);
    add_step("tail_enable", 0, 0, 0, 0, 8'h80, 1);
    add_step("final_drain", 0, 0, 0, 0, 8'h00, 1);
    add_step("empty_in1", 0, 0, 1, 1, 8'h00, 1);
    add_step("res_reuse", 1, 2, 0, 0, 8'h00, 1);
    add_step("idle_end", 0, 0, 0, 0, 8'h00, 1);
  endtask

  task automatic drive_step(input int idx);
    step_t       s;
    logic [31:0] rnd;
    s            = steps[idx];
    rnd          = $urandom();
    res_ready_i  = s.res_req;
    res_id_i     = s.res_id;
    in_valid_i   = s.in_valid;
    in_msg_i     = {rnd[MsgWidth-1:IdWidth], s.in_id};
    release_en_i = s.en;
    out_ready_i  = s.out_ready;
  endtask

  // Compare the outputs with the model, then advance the model to the edge
  task automatic check_and_model(input int idx);
    step_t      s;
    string      nm;
    logic       exp_rv;
    slot_t      exp_rs;
    logic       exp_ir;
    slot_mask_t exp_rel;
    logic       pop_v;
    id_t        pop_id;
    slot_t      slot;
    s       = steps[idx];
    nm      = names[idx];
    exp_rv  = 1'b0;
    exp_rs  = '0;
    pop_id  = '0;
    for (int i = 0; i < NumSlots; i++) begin
      if (!occ_m[i] && !exp_rv) begin
        exp_rs = slot_t'(i);
        exp_rv = 1'b1;
      end
    end
    exp_ir  = s.in_valid && (resv_m[s.in_id].size() != 0);
    exp_rel = (out_valid_m && s.out_ready) ? (slot_mask_t'(1) << out_slot_m) : '0;

    if (res_valid_o !== exp_rv) begin
      $display("MISMATCH %s res_valid_o expected %0d actual %0d", nm, exp_rv, res_valid_o);
      errors++;
    end
    if (exp_rv && (res_slot_o !== exp_rs)) begin
      $display("MISMATCH %s res_slot_o expected %0d actual %0d", nm, exp_rs, res_slot_o);
      errors++;
    end
    if (in_ready_o !== exp_ir) begin
      $display("MISMATCH %s in_ready_o expected %0d actual %0d", nm, exp_ir, in_ready_o);
      errors++;
    end
    if (out_valid_o !== out_valid_m) begin
      $display("MISMATCH %s out_valid_o expected %0d actual %0d", nm, out_valid_m, out_valid_o);
      errors++;
    end
    if (out_valid_m && (out_msg_o !== out_msg_m)) begin
      $display("MISMATCH %s out_msg_o expected %h actual %h", nm, out_msg_m, out_msg_o);
      errors++;
    end
    if (released_o !== exp_rel) begin
      $display("MISMATCH %s released_o expected %b actual %b", nm, exp_rel, released_o);
      errors++;
    end

    // Lowest filled ID whose oldest slot is enabled, if the register can take it
    pop_v = 1'b0;
    if (!out_valid_m || s.out_ready) begin
      for (int i = 0; i < NumIds; i++) begin
        if (!pop_v && (filled_m[i].size() != 0) && s.en[filled_m[i][0]]) begin
          pop_v  = 1'b1;
          pop_id = id_t'(i);
        end
      end
    end
    occ_m = occ_m & ~exp_rel;
    if (out_valid_m && s.out_ready) begin
      out_valid_m = 1'b0;
    end
    if (pop_v) begin
      slot        = filled_m[pop_id].pop_front();
      out_msg_m   = store_m[slot];
      out_slot_m  = slot;
      out_valid_m = 1'b1;
    end
    if (exp_ir) begin
      slot          = resv_m[s.in_id].pop_front();
      store_m[slot] = in_msg_i;
      filled_m[s.in_id].push_back(slot);
    end
    if (s.res_req && exp_rv) begin
      occ_m[exp_rs] = 1'b1;
      resv_m[s.res_id].push_back(exp_rs);
    end
  endtask

  initial begin
    void'($urandom(27673));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    res_id_i     = '0;
    res_ready_i  = 1'b0;
    in_valid_i   = 1'b0;
    in_msg_i     = '0;
    release_en_i = '0;
    out_ready_i  = 1'b0;
    errors       = 0;
    occ_m        = '0;
    out_valid_m  = 1'b0;
    out_msg_m    = '0;
    out_slot_m   = '0;
    build_table();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      @(negedge clk_i);
      drive_step(i);
      #25;
      check_and_model(i);
    end
    $display("Run complete: %0d steps, %0d errors", steps.size(), errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #1;
    #((steps.size() + 20) * 100);
    $display("Watchdog timeout, the stimulus table did not complete in time");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: verilog/wrb_bank_top.sv
//////////////////////////////////////////////////////////////////////
// Top level of the write-response bank
// Connects slot allocator, per-ID lists and release arbiter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wrb_bank_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Reservation port
  input  wrb_pkg::id_t        res_id_i,
  input  logic                res_ready_i,
  output logic                res_valid_o,
  output wrb_pkg::slot_t      res_slot_o,
  // Input port
  input  logic                in_valid_i,
  input  wrb_pkg::msg_t       in_msg_i,
  output logic                in_ready_o,
  // Release enables and output port
  input  wrb_pkg::slot_mask_t release_en_i,
  input  logic                out_ready_i,
  output logic                out_valid_o,
  output wrb_pkg::msg_t       out_msg_o,
  output wrb_pkg::slot_mask_t released_o
);

  import wrb_pkg::*;

  wrb_grant_t grant;
  wrb_pop_t   pop;
  wrb_tails_t tails;
  id_mask_t   filled;
  msg_t       pop_msg;

  wrb_slot_alloc u_slot_alloc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res_id_i    (res_id_i),
    .res_ready_i (res_ready_i),
    .freed_i     (released_o),
    .res_valid_o (res_valid_o),
    .res_slot_o  (res_slot_o),
    .grant_o     (grant)
  );

  wrb_id_lists u_id_lists (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .grant_i    (grant),
    .in_valid_i (in_valid_i),
    .in_msg_i   (in_msg_i),
    .pop_i      (pop),
    .in_ready_o (in_ready_o),
    .tails_o    (tails),
    .filled_o   (filled),
    .pop_msg_o  (pop_msg)
  );

  wrb_release_arb u_release_arb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .release_en_i (release_en_i),
    .tails_i      (tails),
    .filled_i     (filled),
    .pop_msg_i    (pop_msg),
    .out_ready_i  (out_ready_i),
    .pop_o        (pop),
    .out_valid_o  (out_valid_o),
    .out_msg_o    (out_msg_o),
    .released_o   (released_o)
  );

endmodule

// File: verilog/wrb_release_arb.sv
//////////////////////////////////////////////////////////////////////
// Release arbiter of the write-response bank
// Lowest-ID selection among release-enabled tails
// Output register with valid/ready and one-hot released report
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wrb_release_arb (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  wrb_pkg::slot_mask_t release_en_i,
  input  wrb_pkg::wrb_tails_t tails_i,
  input  wrb_pkg::id_mask_t   filled_i,
  input  wrb_pkg::msg_t       pop_msg_i,
  input  logic                out_ready_i,
  output wrb_pkg::wrb_pop_t   pop_o,
  output logic                out_valid_o,
  output wrb_pkg::msg_t       out_msg_o,
  output wrb_pkg::slot_mask_t released_o
);

  import wrb_pkg::*;

  id_mask_t cand;
  logic     out_valid_q;
  wrb_out_t out_q;
  logic     drain;

  assign drain = out_valid_q && out_ready_i;

  // Candidate IDs and lowest-ID priority
  always_comb begin
    pop_o = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      cand[i] = filled_i[i] && release_en_i[tails_i[i]];
      if (cand[i]) begin
        pop_o.id   = id_t'(i);
        pop_o.slot = tails_i[i];
      end
    end
    // Register must be empty or handing over this cycle
    pop_o.valid = (|cand) && (!out_valid_q || out_ready_i);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (pop_o.valid) begin
      out_valid_q <= 1'b1;
    end else if (drain) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o.valid) begin
      out_q.msg  <= pop_msg_i;
      out_q.slot <= pop_o.slot;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_msg_o   = out_q.msg;
  assign released_o  = drain ? (slot_mask_t'(1) << out_q.slot) : '0;

endmodule

// File: verilog/wrb_id_lists.sv
//////////////////////////////////////////////////////////////////////
// Per-ID linked lists of the write-response bank
// Tail, fill and head pointers with their counters
// Next-slot array and message store with combinational read
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wrb_id_lists (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  wrb_pkg::wrb_grant_t grant_i,
  input  logic                in_valid_i,
  input  wrb_pkg::msg_t       in_msg_i,
  input  wrb_pkg::wrb_pop_t   pop_i,
  output logic                in_ready_o,
  output wrb_pkg::wrb_tails_t tails_o,
  output wrb_pkg::id_mask_t   filled_o,
  output wrb_pkg::msg_t       pop_msg_o
);

  import wrb_pkg::*;

  // Counts reach NumSlots, so one bit wider than a slot index
  typedef logic [SlotWidth:0] count_t;

  id_t                 in_id;
  logic                fill_fire;

  // Oldest slot, oldest unfilled reserved slot, newest slot
  slot_t [NumIds-1:0]  tail_q, tail_d;
  slot_t [NumIds-1:0]  fill_q, fill_d;
  slot_t [NumIds-1:0]  head_q, head_d;
  count_t [NumIds-1:0] resv_cnt_q, resv_cnt_d;
  count_t [NumIds-1:0] fill_cnt_q, fill_cnt_d;

  id_mask_t            grant_hit;
  id_mask_t            fill_hit;
  id_mask_t            pop_hit;
  id_mask_t            list_empty;

  slot_t               next_q [NumSlots];
  msg_t                mem_q  [NumSlots];

  assign in_id      = in_msg_i[IdWidth-1:0];
  assign in_ready_o = in_valid_i && (resv_cnt_q[in_id] != '0);
  assign fill_fire  = in_ready_o;

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      grant_hit[i]  = grant_i.valid && (grant_i.id == id_t'(i));
      fill_hit[i]   = fill_fire && (in_id == id_t'(i));
      pop_hit[i]    = pop_i.valid && (pop_i.id == id_t'(i));
      list_empty[i] = (resv_cnt_q[i] == '0) && (fill_cnt_q[i] == '0);
      filled_o[i]   = fill_cnt_q[i] != '0;
    end
  end

  always_comb begin
    tail_d     = tail_q;
    fill_d     = fill_q;
    head_d     = head_q;
    resv_cnt_d = resv_cnt_q;
    fill_cnt_d = fill_cnt_q;
    for (int i = 0; i < NumIds; i++) begin
      if (grant_hit[i]) begin
        head_d[i] = grant_i.slot;
        if (list_empty[i]) begin
          tail_d[i] = grant_i.slot;
          fill_d[i] = grant_i.slot;
        end else if (resv_cnt_q[i] == '0) begin
          fill_d[i] = grant_i.slot;
        end
      end
      // The link of the old head is written at this edge, so forward the grant
      if (fill_hit[i]) begin
        fill_d[i] = (grant_hit[i] && (fill_q[i] == head_q[i])) ?
                    grant_i.slot : next_q[fill_q[i]];
      end
      if (pop_hit[i]) begin
        tail_d[i] = (grant_hit[i] && (tail_q[i] == head_q[i])) ?
                    grant_i.slot : next_q[tail_q[i]];
      end
      resv_cnt_d[i] = resv_cnt_q[i] + count_t'(grant_hit[i]) - count_t'(fill_hit[i]);
      fill_cnt_d[i] = fill_cnt_q[i] + count_t'(fill_hit[i]) - count_t'(pop_hit[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tail_q     <= '0;
      fill_q     <= '0;
      head_q     <= '0;
      resv_cnt_q <= '0;
      fill_cnt_q <= '0;
    end else begin
      tail_q     <= tail_d;
      fill_q     <= fill_d;
      head_q     <= head_d;
      resv_cnt_q <= resv_cnt_d;
      fill_cnt_q <= fill_cnt_d;
    end
  end

  // Link the new slot behind the current head of a non-empty list
  always_ff @(posedge clk_i) begin
    if (grant_i.valid && !list_empty[grant_i.id]) begin
      next_q[head_q[grant_i.id]] <= grant_i.slot;
    end
    if (fill_fire) begin
      mem_q[fill_q[in_id]] <= in_msg_i;
    end
  end

  assign tails_o   = tail_q;
  assign pop_msg_o = mem_q[pop_i.slot];

endmodule

// File: verilog/wrb_slot_alloc.sv
//////////////////////////////////////////////////////////////////////
// Slot allocator of the write-response bank
// Occupancy bits, lowest-free-slot search, reservation handshake
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wrb_slot_alloc (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  wrb_pkg::id_t        res_id_i,
  input  logic                res_ready_i,
  input  wrb_pkg::slot_mask_t freed_i,
  output logic                res_valid_o,
  output wrb_pkg::slot_t      res_slot_o,
  output wrb_pkg::wrb_grant_t grant_o
);

  import wrb_pkg::*;

  slot_mask_t occ_q;
  slot_mask_t occ_d;
  slot_mask_t res_mask;
  logic       res_hs;

  // Scan downwards so the lowest clear bit is the last one written
  always_comb begin
    res_slot_o = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        res_slot_o = slot_t'(i);
      end
    end
  end

  assign res_valid_o = ~&occ_q;
  assign res_hs      = res_valid_o && res_ready_i;

  assign grant_o.valid = res_hs;
  assign grant_o.id    = res_id_i;
  assign grant_o.slot  = res_slot_o;

  // A free slot is never in freed_i, so set and clear do not collide
  assign res_mask = res_hs ? (slot_mask_t'(1) << res_slot_o) : '0;
  assign occ_d    = (occ_q & ~freed_i) | res_mask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

// File: verilog/wrb_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths and types of the write-response bank
// Vector typedefs for IDs, slots, masks and messages
// Packed structs for grants, pops and the output register
//////////////////////////////////////////////////////////////////////

package wrb_pkg;

  localparam int IdWidth   = 2;
  localparam int NumIds    = 4;
  localparam int NumSlots  = 8;
  localparam int SlotWidth = 3;
  localparam int MsgWidth  = 16;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [SlotWidth-1:0] slot_t;
  typedef logic [NumSlots-1:0]  slot_mask_t;
  typedef logic [NumIds-1:0]    id_mask_t;
  // Lower IdWidth bits carry the transaction ID
  typedef logic [MsgWidth-1:0]  msg_t;

  // Completed reservation
  typedef struct packed {
    logic  valid;
    id_t   id;
    slot_t slot;
  } wrb_grant_t;

  // Release decision taken by the arbiter
  typedef struct packed {
    logic  valid;
    id_t   id;
    slot_t slot;
  } wrb_pop_t;

  // Content of the output register
  typedef struct packed {
    msg_t  msg;
    slot_t slot;
  } wrb_out_t;

  typedef slot_t [NumIds-1:0] wrb_tails_t;

endpackage
